// File: include/timer1_settings.svh
// Timer1 register map, waveform and clock-select codes, fixed TOP values
// and the widths of the bus, counter and prescaler divider

`ifndef TIMER1_SETTINGS_SVH
`define TIMER1_SETTINGS_SVH

`define TIMER1_ADDR_W   6
`define TIMER1_DATA_W   8
`define TIMER1_COUNT_W  16
`define TIMER1_PRESC_W  11  // Enough for divide by 1024

// I/O addresses
`define TIMER1_ADDR_TCCR1A  6'h20
`define TIMER1_ADDR_TCCR1B  6'h21
`define TIMER1_ADDR_OCR1AL  6'h28
`define TIMER1_ADDR_OCR1AH  6'h29
`define TIMER1_ADDR_OCR1BL  6'h2A
`define TIMER1_ADDR_OCR1BH  6'h2B
`define TIMER1_ADDR_TCNT1L  6'h2C
`define TIMER1_ADDR_TCNT1H  6'h2D
`define TIMER1_ADDR_TIMSK1  6'h2F
`define TIMER1_ADDR_TIFR1   6'h16

// Shared bit positions of TIFR1 and TIMSK1
`define TIMER1_FLAG_TOV   0
`define TIMER1_FLAG_OCFA  1
`define TIMER1_FLAG_OCFB  2

`define TIMER1_TOP_8BIT   16'h00FF
`define TIMER1_TOP_9BIT   16'h01FF
`define TIMER1_TOP_10BIT  16'h03FF
`define TIMER1_TOP_MAX    16'hFFFF

// WGM13:0 codes
`define TIMER1_WGM_NORMAL     4'b0000
`define TIMER1_WGM_CTC_OCRA   4'b0100
`define TIMER1_WGM_FAST_8     4'b0101
`define TIMER1_WGM_FAST_9     4'b0110
`define TIMER1_WGM_FAST_10    4'b0111
`define TIMER1_WGM_FAST_OCRA  4'b1111

// CS12:0 codes
`define TIMER1_CS_STOP      3'b000
`define TIMER1_CS_DIV1      3'b001
`define TIMER1_CS_DIV8      3'b010
`define TIMER1_CS_DIV64     3'b011
`define TIMER1_CS_DIV256    3'b100
`define TIMER1_CS_DIV1024   3'b101
`define TIMER1_CS_EXT_FALL  3'b110
`define TIMER1_CS_EXT_RISE  3'b111

`endif

// File: hdl/timer1_pkg.sv
// Timer1 types: bus address and data, counter value,
// waveform mode, clock select and compare-output mode enums
`default_nettype none

`include "timer1_settings.svh"

package timer1_pkg;

    typedef logic [`TIMER1_ADDR_W-1:0]  io_addr_t;
    typedef logic [`TIMER1_DATA_W-1:0]  io_data_t;
    typedef logic [`TIMER1_COUNT_W-1:0] count_t;  // Counter, compare and TOP

    typedef enum logic [3:0] {
        wgm_normal    = `TIMER1_WGM_NORMAL,
        wgm_ctc_ocra  = `TIMER1_WGM_CTC_OCRA,
        wgm_fast_8    = `TIMER1_WGM_FAST_8,
        wgm_fast_9    = `TIMER1_WGM_FAST_9,
        wgm_fast_10   = `TIMER1_WGM_FAST_10,
        wgm_fast_ocra = `TIMER1_WGM_FAST_OCRA
    } wgm_t;

    typedef enum logic [2:0] {
        cs_stop     = `TIMER1_CS_STOP,
        cs_div1     = `TIMER1_CS_DIV1,
        cs_div8     = `TIMER1_CS_DIV8,
        cs_div64    = `TIMER1_CS_DIV64,
        cs_div256   = `TIMER1_CS_DIV256,
        cs_div1024  = `TIMER1_CS_DIV1024,
        cs_ext_fall = `TIMER1_CS_EXT_FALL,
        cs_ext_rise = `TIMER1_CS_EXT_RISE
    } clock_select_t;

    typedef enum logic [1:0] {
        com_off      = 2'b00,
        com_reserved = 2'b01,
        com_clear    = 2'b10,  // Non-inverting
        com_set      = 2'b11   // Inverting
    } com_t;

endpackage

`default_nettype wire

// File: hdl/timer1_prescaler.sv
// Timer1 clock-select prescaler
// Registered divider producing one-cycle count ticks
`timescale 1ns/1ps
`default_nettype none

`include "timer1_settings.svh"

module timer1_prescaler (
    input  logic                      clk,
    input  logic                      reset_n,
    input  timer1_pkg::clock_select_t clock_select,
    output logic                      tick
);
    import timer1_pkg::*;

    logic [`TIMER1_PRESC_W-1:0] div_count;
    logic [`TIMER1_PRESC_W-1:0] terminal;
    logic                       active;

    // Terminal value is ratio minus one
    always_comb begin
        active   = 1'b1;
        terminal = '0;
        case (clock_select)
            cs_div1:    terminal = 11'd0;
            cs_div8:    terminal = 11'd7;
            cs_div64:   terminal = 11'd63;
            cs_div256:  terminal = 11'd255;
            cs_div1024: terminal = 11'd1023;
            default:    active   = 1'b0;  // Stop and external inputs
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_count <= '0;
            tick      <= 1'b0;
        end else if (!active) begin
            div_count <= '0;
            tick      <= 1'b0;
        end else if (div_count >= terminal) begin  // Also catches a ratio change
            div_count <= '0;
            tick      <= 1'b1;
        end else begin
            div_count <= div_count + 1'b1;
            tick      <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/timer1_counter.sv
// Timer1 16-bit counter with TOP selection
// and registered overflow, wrap and compare-match pulses
`timescale 1ns/1ps
`default_nettype none

`include "timer1_settings.svh"

module timer1_counter (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               tick,
    input  timer1_pkg::wgm_t   mode,
    input  timer1_pkg::count_t ocr_a,
    input  timer1_pkg::count_t ocr_b,
    input  logic               tcnt_load,
    input  timer1_pkg::count_t tcnt_load_value,
    output timer1_pkg::count_t count,
    output logic               overflow,
    output logic               match_a,
    output logic               match_b,
    output logic               wrap
);
    import timer1_pkg::*;

    count_t top;
    count_t count_next;
    logic   is_fast;
    logic   is_ctc;
    logic   at_top;

    always_comb begin
        case (mode)
            wgm_ctc_ocra,
            wgm_fast_ocra: top = ocr_a;
            wgm_fast_8:    top = `TIMER1_TOP_8BIT;
            wgm_fast_9:    top = `TIMER1_TOP_9BIT;
            wgm_fast_10:   top = `TIMER1_TOP_10BIT;
            default:       top = `TIMER1_TOP_MAX;
        endcase
    end

    assign is_ctc  = (mode == wgm_ctc_ocra);
    assign is_fast = (mode == wgm_fast_8) || (mode == wgm_fast_9) ||
                     (mode == wgm_fast_10) || (mode == wgm_fast_ocra);
    assign at_top  = (count == top);

    // Normal mode rolls over by itself at TOP_MAX
    assign count_next = ((is_fast || is_ctc) && at_top) ? '0 : count + 1'b1;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count    <= '0;
            overflow <= 1'b0;
            wrap     <= 1'b0;
            match_a  <= 1'b0;
            match_b  <= 1'b0;
        end else begin
            overflow <= 1'b0;
            wrap     <= 1'b0;
            match_a  <= 1'b0;
            match_b  <= 1'b0;
            if (tcnt_load) begin
                count <= tcnt_load_value;  // CPU write wins over the tick
            end else if (tick) begin
                count    <= count_next;
                overflow <= at_top && !is_ctc;
                wrap     <= at_top && is_fast;
                match_a  <= (count == ocr_a);
                match_b  <= (count == ocr_b);
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/timer1_waveform.sv
// Timer1 compare-output pins OC1A and OC1B
// Fast-PWM set/clear on wrap and compare match
`timescale 1ns/1ps
`default_nettype none

module timer1_waveform (
    input  logic             clk,
    input  logic             reset_n,
    input  timer1_pkg::wgm_t mode,
    input  timer1_pkg::com_t com_a,
    input  timer1_pkg::com_t com_b,
    input  logic             match_a,
    input  logic             match_b,
    input  logic             wrap,
    output logic             oc1a,
    output logic             oc1b
);
    import timer1_pkg::*;

    logic is_fast;

    // Next pin level for one channel, wrap has priority over match
    function automatic logic pin_next(input com_t com, input logic match,
                                      input logic wrap_evt, input logic pin);
        logic result;
        result = pin;
        if (com == com_clear || com == com_set) begin
            if (wrap_evt)
                result = (com == com_clear);
            else if (match)
                result = (com == com_set);
        end
        return result;
    endfunction

    assign is_fast = (mode == wgm_fast_8) || (mode == wgm_fast_9) ||
                     (mode == wgm_fast_10) || (mode == wgm_fast_ocra);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            oc1a <= 1'b0;
            oc1b <= 1'b0;
        end else if (is_fast) begin  // Pins frozen outside fast PWM
            oc1a <= pin_next(com_a, match_a, wrap, oc1a);
            oc1b <= pin_next(com_b, match_b, wrap, oc1b);
        end
    end

endmodule

`default_nettype wire

// File: hdl/timer1_regs.sv
// Timer1 register block: control, compare, mask and flag registers,
// TCNT temporary byte, mode decode, interrupt gating and read mux
`timescale 1ns/1ps
`default_nettype none

`include "timer1_settings.svh"

module timer1_regs (
    input  logic                          clk,
    input  logic                          reset_n,
    input  timer1_pkg::io_addr_t          io_addr,
    input  timer1_pkg::io_data_t          io_data_in,
    input  logic                          io_write,
    input  logic                          io_read,
    output timer1_pkg::io_data_t          io_data_out,
    input  timer1_pkg::count_t            count,
    input  logic                          overflow,
    input  logic                          match_a,
    input  logic                          match_b,
    output timer1_pkg::clock_select_t     clock_select,
    output timer1_pkg::wgm_t              mode,
    output timer1_pkg::com_t              com_a,
    output timer1_pkg::com_t              com_b,
    output timer1_pkg::count_t            ocr_a,
    output timer1_pkg::count_t            ocr_b,
    output logic                          tcnt_load,
    output timer1_pkg::count_t            tcnt_load_value,
    output logic                          irq_overflow,
    output logic                          irq_compa,
    output logic                          irq_compb
);
    import timer1_pkg::*;

    io_data_t   tccr1a;
    io_data_t   tccr1b;
    io_data_t   timsk1;
    io_data_t   tcnt_temp;   // Low byte waits for the high byte
    logic [2:0] tifr1;
    logic [2:0] flag_set;
    logic [2:0] flag_clear;
    logic [3:0] wgm_code;

    // Register writes and flag updates
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tccr1a    <= '0;
            tccr1b    <= '0;
            timsk1    <= '0;
            tcnt_temp <= '0;
            ocr_a     <= '0;
            ocr_b     <= '0;
            tifr1     <= '0;
        end else begin
            if (io_write) begin
                case (io_addr)
                    `TIMER1_ADDR_TCNT1L: tcnt_temp   <= io_data_in;
                    `TIMER1_ADDR_TCCR1A: tccr1a      <= io_data_in;
                    `TIMER1_ADDR_TCCR1B: tccr1b      <= io_data_in;
                    `TIMER1_ADDR_OCR1AL: ocr_a[7:0]  <= io_data_in;
                    `TIMER1_ADDR_OCR1AH: ocr_a[15:8] <= io_data_in;
                    `TIMER1_ADDR_OCR1BL: ocr_b[7:0]  <= io_data_in;
                    `TIMER1_ADDR_OCR1BH: ocr_b[15:8] <= io_data_in;
                    `TIMER1_ADDR_TIMSK1: timsk1      <= io_data_in;
                    default: ;
                endcase
            end
            tifr1 <= (tifr1 & ~flag_clear) | flag_set;  // Set beats clear
        end
    end

    always_comb begin
        flag_set                     = '0;
        flag_set[`TIMER1_FLAG_TOV]   = overflow;
        flag_set[`TIMER1_FLAG_OCFA]  = match_a;
        flag_set[`TIMER1_FLAG_OCFB]  = match_b;
        flag_clear = (io_write && io_addr == `TIMER1_ADDR_TIFR1) ? io_data_in[2:0] : '0;
    end

    // High byte write loads the counter at the same edge
    assign tcnt_load       = io_write && (io_addr == `TIMER1_ADDR_TCNT1H);
    assign tcnt_load_value = {io_data_in, tcnt_temp};

    // Mode and output fields
    assign wgm_code     = {tccr1b[4:3], tccr1a[1:0]};
    assign clock_select = clock_select_t'(tccr1b[2:0]);
    assign com_a        = com_t'(tccr1a[7:6]);
    assign com_b        = com_t'(tccr1a[5:4]);

    always_comb begin
        case (wgm_code)
            wgm_ctc_ocra, wgm_fast_8, wgm_fast_9, wgm_fast_10, wgm_fast_ocra:
                mode = wgm_t'(wgm_code);
            default: mode = wgm_normal;  // Dropped modes fall back to normal
        endcase
    end

    assign irq_overflow = tifr1[`TIMER1_FLAG_TOV]  & timsk1[`TIMER1_FLAG_TOV];
    assign irq_compa    = tifr1[`TIMER1_FLAG_OCFA] & timsk1[`TIMER1_FLAG_OCFA];
    assign irq_compb    = tifr1[`TIMER1_FLAG_OCFB] & timsk1[`TIMER1_FLAG_OCFB];

    // Read mux, TCNT shows the live count
    always_comb begin
        io_data_out = '0;
        if (io_read) begin
            case (io_addr)
                `TIMER1_ADDR_TCNT1L: io_data_out = count[7:0];
                `TIMER1_ADDR_TCNT1H: io_data_out = count[15:8];
                `TIMER1_ADDR_TCCR1A: io_data_out = tccr1a;
                `TIMER1_ADDR_TCCR1B: io_data_out = tccr1b;
                `TIMER1_ADDR_OCR1AL: io_data_out = ocr_a[7:0];
                `TIMER1_ADDR_OCR1AH: io_data_out = ocr_a[15:8];
                `TIMER1_ADDR_OCR1BL: io_data_out = ocr_b[7:0];
                `TIMER1_ADDR_OCR1BH: io_data_out = ocr_b[15:8];
                `TIMER1_ADDR_TIMSK1: io_data_out = timsk1;
                `TIMER1_ADDR_TIFR1:  io_data_out = {5'b00000, tifr1};
                default:             io_data_out = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/timer1_top.sv
// Timer1 top level
// Register block beside prescaler, counter and waveform pins
`timescale 1ns/1ps
`default_nettype none

module timer1_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  timer1_pkg::io_addr_t io_addr,
    input  timer1_pkg::io_data_t io_data_in,
    input  logic                 io_write,
    input  logic                 io_read,
    output timer1_pkg::io_data_t io_data_out,
    output logic                 oc1a,
    output logic                 oc1b,
    output logic                 irq_overflow,
    output logic                 irq_compa,
    output logic                 irq_compb
);
    import timer1_pkg::*;

    clock_select_t clock_select;
    wgm_t          mode;
    com_t          com_a;
    com_t          com_b;
    count_t        ocr_a;
    count_t        ocr_b;
    count_t        tcnt_load_value;
    count_t        count;
    logic          tcnt_load;
    logic          tick;
    logic          overflow;
    logic          match_a;
    logic          match_b;
    logic          wrap;

    timer1_regs i_regs (
        .clk             (clk),
        .reset_n         (reset_n),
        .io_addr         (io_addr),
        .io_data_in      (io_data_in),
        .io_write        (io_write),
        .io_read         (io_read),
        .io_data_out     (io_data_out),
        .count           (count),
        .overflow        (overflow),
        .match_a         (match_a),
        .match_b         (match_b),
        .clock_select    (clock_select),
        .mode            (mode),
        .com_a           (com_a),
        .com_b           (com_b),
        .ocr_a           (ocr_a),
        .ocr_b           (ocr_b),
        .tcnt_load       (tcnt_load),
        .tcnt_load_value (tcnt_load_value),
        .irq_overflow    (irq_overflow),
        .irq_compa       (irq_compa),
        .irq_compb       (irq_compb)
    );

    timer1_prescaler i_prescaler (
        .clk          (clk),
        .reset_n      (reset_n),
        .clock_select (clock_select),
        .tick         (tick)
    );

    timer1_counter i_counter (
        .clk             (clk),
        .reset_n         (reset_n),
        .tick            (tick),
        .mode            (mode),
        .ocr_a           (ocr_a),
        .ocr_b           (ocr_b),
        .tcnt_load       (tcnt_load),
        .tcnt_load_value (tcnt_load_value),
        .count           (count),
        .overflow        (overflow),
        .match_a         (match_a),
        .match_b         (match_b),
        .wrap            (wrap)
    );

    timer1_waveform i_waveform (
        .clk     (clk),
        .reset_n (reset_n),
        .mode    (mode),
        .com_a   (com_a),
        .com_b   (com_b),
        .match_a (match_a),
        .match_b (match_b),
        .wrap    (wrap),
        .oc1a    (oc1a),
        .oc1b    (oc1b)
    );

endmodule

`default_nettype wire

// File: sim/tb_timer1.sv
// Timer1 testbench: clock and reset, bus tasks, xorshift stimulus,
// reference models, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "timer1_settings.svh"

module tb_timer1;
    import timer1_pkg::*;

    localparam int clk_period    = 20;
    // Cycle budget of each test, summed by the watchdog
    localparam int regs_cycles   = 200;
    localparam int tcnt_cycles   = 200;
    localparam int presc_cycles  = 900;
    localparam int ctc_cycles    = 800;
    localparam int pwm_cycles    = 4 * 256 + 4 * 512 + 200;
    localparam int margin_cycles = 1000;

    logic     clk;
    logic     reset_n;
    io_addr_t io_addr;
    io_data_t io_data_in;
    logic     io_write;
    logic     io_read;
    io_data_t io_data_out;
    logic     oc1a;
    logic     oc1b;
    logic     irq_overflow;
    logic     irq_compa;
    logic     irq_compb;

    logic [31:0]      rng;
    logic [63:0][7:0] reg_model;  // Last byte written, by address

    timer1_top i_timer1_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .io_addr      (io_addr),
        .io_data_in   (io_data_in),
        .io_write     (io_write),
        .io_read      (io_read),
        .io_data_out  (io_data_out),
        .oc1a         (oc1a),
        .oc1b         (oc1b),
        .irq_overflow (irq_overflow),
        .irq_compa    (irq_compa),
        .irq_compb    (irq_compb)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic is_mapped(input io_addr_t addr);
        case (addr)
            `TIMER1_ADDR_TCNT1L, `TIMER1_ADDR_TCNT1H, `TIMER1_ADDR_TCCR1A,
            `TIMER1_ADDR_TCCR1B, `TIMER1_ADDR_OCR1AL, `TIMER1_ADDR_OCR1AH,
            `TIMER1_ADDR_OCR1BL, `TIMER1_ADDR_OCR1BH, `TIMER1_ADDR_TIMSK1,
            `TIMER1_ADDR_TIFR1: return 1'b1;
            default:            return 1'b0;
        endcase
    endfunction

    // Control and compare registers read back as written
    function automatic io_data_t expected_read(input logic [63:0][7:0] model,
                                               input io_addr_t addr);
        if (!is_mapped(addr))
            return '0;
        return model[addr];
    endfunction

    // High cycles of one pin over a fast-PWM period of top + 1
    function automatic count_t expected_high_cycles(input count_t top, input count_t cmp,
                                                    input com_t com);
        count_t period;
        count_t high;
        period = top + 16'd1;
        high   = (cmp >= top) ? period : cmp + 16'd1;
        if (com == com_set)
            high = period - high;  // Inverting output
        return high;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input io_data_t exp, input io_data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic bus_write(input io_addr_t addr, input io_data_t data);
        @(posedge clk);
        #2;
        io_addr    = addr;
        io_data_in = data;
        io_write   = 1'b1;
        io_read    = 1'b0;
        @(posedge clk);  // Write lands on this edge
        #2;
        io_write   = 1'b0;
    endtask

    task automatic bus_read(input io_addr_t addr, output io_data_t data);
        @(posedge clk);
        #2;
        io_addr = addr;
        io_read = 1'b1;
        #5;
        data    = io_data_out;
        io_read = 1'b0;
    endtask

    task automatic write_word(input io_addr_t lo, input io_addr_t hi, input count_t value);
        bus_write(lo, value[7:0]);   // Low byte first for TCNT
        bus_write(hi, value[15:8]);
    endtask

    // Repeats until the high byte is the same on both sides of the low read
    task automatic read_tcnt(output count_t value);
        io_data_t hi;
        io_data_t lo;
        io_data_t hi2;
        do begin
            bus_read(`TIMER1_ADDR_TCNT1H, hi);
            bus_read(`TIMER1_ADDR_TCNT1L, lo);
            bus_read(`TIMER1_ADDR_TCNT1H, hi2);
        end while (hi != hi2);
        value = {hi, lo};
    endtask

    task automatic write_random(input io_addr_t addr, input io_data_t mask);
        io_data_t value;
        rng             = xorshift(rng);
        value           = rng[7:0] & mask;
        bus_write(addr, value);
        reg_model[addr] = value;
    endtask

    task automatic check_readback(input io_addr_t addr, input string name);
        io_data_t got;
        bus_read(addr, got);
        check_byte(name, expected_read(reg_model, addr), got);
    endtask

    task automatic test_register_access();
        io_data_t got;
        io_addr_t addr;
        write_random(`TIMER1_ADDR_TCCR1A, 8'hFF);
        write_random(`TIMER1_ADDR_TCCR1B, 8'hF8);  // Clock select stays at stop
        write_random(`TIMER1_ADDR_OCR1AL, 8'hFF);
        write_random(`TIMER1_ADDR_OCR1AH, 8'hFF);
        write_random(`TIMER1_ADDR_OCR1BL, 8'hFF);
        write_random(`TIMER1_ADDR_OCR1BH, 8'hFF);
        write_random(`TIMER1_ADDR_TIMSK1, 8'hFF);
        check_readback(`TIMER1_ADDR_TCCR1A, "tccr1a readback");
        check_readback(`TIMER1_ADDR_TCCR1B, "tccr1b readback");
        check_readback(`TIMER1_ADDR_OCR1AL, "ocr1al readback");
        check_readback(`TIMER1_ADDR_OCR1AH, "ocr1ah readback");
        check_readback(`TIMER1_ADDR_OCR1BL, "ocr1bl readback");
        check_readback(`TIMER1_ADDR_OCR1BH, "ocr1bh readback");
        check_readback(`TIMER1_ADDR_TIMSK1, "timsk1 readback");
        repeat (4) begin
            do begin
                rng  = xorshift(rng);
                addr = rng[5:0];
            end while (is_mapped(addr));
            bus_read(addr, got);
            check_byte("unmapped read", expected_read(reg_model, addr), got);
        end
        @(posedge clk);
        #2;
        io_addr = `TIMER1_ADDR_TCCR1A;
        io_read = 1'b0;
        #5;
        check_byte("read strobe low", 8'h00, io_data_out);
    endtask

    task automatic test_tcnt_overflow();
        count_t   value;
        count_t   got;
        io_data_t flags;
        io_data_t mask;
        logic     tov_en;
        int       i;
        bus_write(`TIMER1_ADDR_TCCR1B, 8'h00);
        bus_write(`TIMER1_ADDR_TCCR1A, 8'h00);
        rng   = xorshift(rng);
        value = rng[15:0];
        write_word(`TIMER1_ADDR_TCNT1L, `TIMER1_ADDR_TCNT1H, value);
        read_tcnt(got);
        check_count("tcnt readback", value, got);
        rng                   = xorshift(rng);
        tov_en                = rng[0];
        mask                  = '0;
        mask[`TIMER1_FLAG_TOV] = tov_en;
        bus_write(`TIMER1_ADDR_TIMSK1, mask);
        write_word(`TIMER1_ADDR_TCNT1L, `TIMER1_ADDR_TCNT1H, 16'hFFF0);
        bus_write(`TIMER1_ADDR_TIFR1, 8'h07);
        bus_write(`TIMER1_ADDR_TCCR1B, {5'b00000, cs_div1});
        flags = '0;
        i     = 0;
        while (!flags[`TIMER1_FLAG_TOV] && i < 20) begin
            bus_read(`TIMER1_ADDR_TIFR1, flags);
            i++;
        end
        if (!flags[`TIMER1_FLAG_TOV])
            fail_run("Overflow flag was not set within 20 cycles of counting from 16'hFFF0");
        check_bit("overflow irq", tov_en, irq_overflow);
        bus_write(`TIMER1_ADDR_TIFR1, 8'h01 << `TIMER1_FLAG_TOV);  // Write one to clear
        bus_read(`TIMER1_ADDR_TIFR1, flags);
        check_bit("tov cleared", 1'b0, flags[`TIMER1_FLAG_TOV]);
        check_bit("overflow irq cleared", 1'b0, irq_overflow);
    endtask

    task automatic test_prescaler();
        count_t first;
        count_t second;
        count_t diff;
        count_t expected;
        bus_write(`TIMER1_ADDR_TCCR1B, {5'b00000, cs_div8});
        read_tcnt(first);
        repeat (800) @(posedge clk);
        read_tcnt(second);
        diff     = second - first;
        expected = (diff >= 16'd99 && diff <= 16'd101) ? diff : 16'd100;
        check_count("prescaler div8 step", expected, diff);
    endtask

    task automatic test_ctc();
        count_t   ocr;
        count_t   value;
        count_t   bound;
        io_data_t flags;
        int       i;
        bus_write(`TIMER1_ADDR_TCCR1B, 8'h00);
        bus_write(`TIMER1_ADDR_TCCR1A, 8'h00);
        rng = xorshift(rng);
        ocr = 16'd16 + {8'h00, rng[7:0]};  // Short period so OCF1A comes early
        write_word(`TIMER1_ADDR_OCR1AL, `TIMER1_ADDR_OCR1AH, ocr);
        write_word(`TIMER1_ADDR_OCR1BL, `TIMER1_ADDR_OCR1BH, ocr >> 1);  // Halfway up
        bus_write(`TIMER1_ADDR_TIMSK1, 8'h01 << `TIMER1_FLAG_OCFA);  // Compare A irq only
        write_word(`TIMER1_ADDR_TCNT1L, `TIMER1_ADDR_TCNT1H, 16'h0000);
        bus_write(`TIMER1_ADDR_TIFR1, 8'h07);
        bus_write(`TIMER1_ADDR_TCCR1B, {3'b000, 2'b01, cs_div1});  // WGM 0100
        for (i = 0; i < 100; i++) begin
            read_tcnt(value);
            bound = (value > ocr) ? ocr : value;
            check_count("ctc count bound", bound, value);
        end
        bus_read(`TIMER1_ADDR_TIFR1, flags);
        check_bit("ctc ocf1a set", 1'b1, flags[`TIMER1_FLAG_OCFA]);
        check_bit("ctc ocf1b set", 1'b1, flags[`TIMER1_FLAG_OCFB]);
        check_bit("ctc tov clear", 1'b0, flags[`TIMER1_FLAG_TOV]);
        check_bit("ctc compa irq enabled", 1'b1, irq_compa);
        check_bit("ctc compb irq masked", 1'b0, irq_compb);
    endtask

    task automatic test_fast_pwm(input logic [1:0] wgm_low, input count_t top,
                                 input string name_a, input string name_b);
        count_t cmp_a;
        count_t cmp_b;
        count_t high_a;
        count_t high_b;
        count_t period;
        count_t mask;
        int     i;
        period = top + 16'd1;
        mask   = {top[14:0], 1'b1};  // Compare values up to twice TOP
        bus_write(`TIMER1_ADDR_TCCR1B, {3'b000, 2'b01, cs_stop});
        bus_write(`TIMER1_ADDR_TCCR1A, {com_clear, com_set, 2'b00, wgm_low});
        rng   = xorshift(rng);
        cmp_a = rng[15:0] & mask;
        cmp_b = rng[31:16] & mask;
        write_word(`TIMER1_ADDR_OCR1AL, `TIMER1_ADDR_OCR1AH, cmp_a);
        write_word(`TIMER1_ADDR_OCR1BL, `TIMER1_ADDR_OCR1BH, cmp_b);
        write_word(`TIMER1_ADDR_TCNT1L, `TIMER1_ADDR_TCNT1H, 16'h0000);
        bus_write(`TIMER1_ADDR_TCCR1B, {3'b000, 2'b01, cs_div1});
        repeat (2 * period + 4) @(posedge clk);  // Pins settle
        high_a = '0;
        high_b = '0;
        for (i = 0; i < period; i++) begin
            @(negedge clk);
            if (oc1a)
                high_a = high_a + 16'd1;
            if (oc1b)
                high_b = high_b + 16'd1;
        end
        check_count(name_a, expected_high_cycles(top, cmp_a, com_clear), high_a);
        check_count(name_b, expected_high_cycles(top, cmp_b, com_set), high_b);
    endtask

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        io_addr    = '0;
        io_data_in = '0;
        io_write   = 1'b0;
        io_read    = 1'b0;
        rng        = 32'h808f;
        reg_model  = '0;
        repeat (2) @(posedge clk);
        #2;
        reset_n = 1'b1;
        test_register_access();
        test_tcnt_overflow();
        test_prescaler();
        test_ctc();
        test_fast_pwm(2'b01, `TIMER1_TOP_8BIT, "fast8 oc1a duty", "fast8 oc1b duty");
        test_fast_pwm(2'b10, `TIMER1_TOP_9BIT, "fast9 oc1a duty", "fast9 oc1b duty");
        $display("TEST PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #((regs_cycles + tcnt_cycles + presc_cycles + ctc_cycles + pwm_cycles
           + margin_cycles) * clk_period);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
hdl/timer1_pkg.sv
hdl/timer1_prescaler.sv
hdl/timer1_counter.sv
hdl/timer1_waveform.sv
hdl/timer1_regs.sv
hdl/timer1_top.sv
sim/tb_timer1.sv

// File: Bender.yml
package:
  name: timer1

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/timer1_pkg.sv
      - hdl/timer1_prescaler.sv
      - hdl/timer1_counter.sv
      - hdl/timer1_waveform.sv
      - hdl/timer1_regs.sv
      - hdl/timer1_top.sv
      - target: simulation
        files:
          - sim/tb_timer1.sv
